/* hdl/lc4_consts.svh */
// LC4 shared constants
// word, register index and stall code widths, plus instruction field positions
`ifndef LC4_CONSTS_SVH
`define LC4_CONSTS_SVH

// word and field widths
`define LC4_INSN_W      16
`define LC4_REG_IDX_W   3
`define LC4_STALL_W     2

// opcode field
`define LC4_OPCODE_MSB  15
`define LC4_OPCODE_LSB  12

// destination register, also the data source of a store
`define LC4_RD_MSB      11
`define LC4_RD_LSB      9

// first source register
`define LC4_RS_MSB      8
`define LC4_RS_LSB      6

// set when the low five bits hold an immediate instead of rt
`define LC4_IMM_FLAG_BIT 5

// second source register
`define LC4_RT_MSB      2
`define LC4_RT_LSB      0

`endif

/* hdl/lc4_isa_pkg.sv */
// LC4 ISA types
// opcode encoding, register numbers and the two views of an instruction word
`include "lc4_consts.svh"

package lc4_isa_pkg;

    // only the classes the issue stage cares about are named
    typedef enum logic [`LC4_OPCODE_MSB-`LC4_OPCODE_LSB:0] {
        OP_BR    = 4'd0,
        OP_ARITH = 4'd1,
        OP_LOGIC = 4'd5,
        OP_LDR   = 4'd6,
        OP_STR   = 4'd7,
        OP_CONST = 4'd9
    } opcode_e;

    typedef logic [`LC4_REG_IDX_W-1:0] reg_idx_t;

    // register form: rd = rs op rt, sub selects the operation
    typedef struct packed {
        opcode_e                              opcode;
        reg_idx_t                             rd;
        reg_idx_t                             rs;
        logic [`LC4_RS_LSB-`LC4_RT_MSB-2:0]   sub;
        reg_idx_t                             rt;
    } insn_reg_t;

    // immediate form: the flag replaces the top sub bit
    typedef struct packed {
        opcode_e                                   opcode;
        reg_idx_t                                  rd;
        reg_idx_t                                  rs;
        logic                                      imm_flag;
        logic [`LC4_IMM_FLAG_BIT-`LC4_RT_LSB-1:0]  imm;
    } insn_imm_t;

    // same 16 bits, read either way
    typedef union packed {
        insn_reg_t r;
        insn_imm_t i;
    } insn_u;

endpackage

/* hdl/lc4_issue_pkg.sv */
// LC4 issue types
// stall codes reported per lane, numbered as in the full pipeline
`include "lc4_consts.svh"

package lc4_issue_pkg;

    // STALL_BRANCH keeps its slot in the encoding but
    // nothing in the issue stage produces it
    typedef enum logic [`LC4_STALL_W-1:0] {
        STALL_NONE   = 2'd0,
        STALL_PIPE   = 2'd1,
        STALL_BRANCH = 2'd2,
        STALL_LOAD   = 2'd3
    } stall_e;

endpackage

/* hdl/lc4_insn_decoder.sv */
// LC4 instruction decoder
// maps one instruction word to its register reads, writes and memory class
`timescale 1ns/100ps

module lc4_insn_decoder (
    input  lc4_isa_pkg::insn_u    i_insn,
    output lc4_isa_pkg::reg_idx_t o_rs,
    output lc4_isa_pkg::reg_idx_t o_rt,
    output lc4_isa_pkg::reg_idx_t o_rd,
    output logic                  o_rs_re,
    output logic                  o_rt_re,
    output logic                  o_rd_we,
    output logic                  o_nzp_we,
    output logic                  o_is_load,
    output logic                  o_is_store,
    output logic                  o_is_branch
);

    always_comb begin
        o_rs_re     = 1'b0;
        o_rt_re     = 1'b0;
        o_rd_we     = 1'b0;
        o_nzp_we    = 1'b0;
        o_is_load   = 1'b0;
        o_is_store  = 1'b0;
        o_is_branch = 1'b0;

        case (i_insn.r.opcode)
            lc4_isa_pkg::OP_ARITH,
            lc4_isa_pkg::OP_LOGIC: begin
                o_rs_re  = 1'b1;
                // immediate form has no rt, the low bits are data
                o_rt_re  = ~i_insn.i.imm_flag;
                o_rd_we  = 1'b1;
                o_nzp_we = 1'b1;
            end

            lc4_isa_pkg::OP_LDR: begin
                o_rs_re   = 1'b1;
                o_rd_we   = 1'b1;
                o_nzp_we  = 1'b1;
                o_is_load = 1'b1;
            end

            lc4_isa_pkg::OP_STR: begin
                // base in rs, data register in rd
                o_rs_re    = 1'b1;
                o_rt_re    = 1'b1;
                o_is_store = 1'b1;
            end

            lc4_isa_pkg::OP_CONST: begin
                o_rd_we  = 1'b1;
                o_nzp_we = 1'b1;
            end

            lc4_isa_pkg::OP_BR: begin
                // reads only the NZP bits
                o_is_branch = 1'b1;
            end

            default: begin
                o_is_branch = 1'b0;
            end
        endcase
    end

    assign o_rs = i_insn.r.rs;
    assign o_rd = i_insn.r.rd;

    // a store's data register is reported as the second read
    assign o_rt = o_is_store ? i_insn.r.rd : i_insn.r.rt;

endmodule

/* hdl/lc4_pair_issue.sv */
// LC4 pair issue unit
// checks load-to-use, intra-pair and memory hazards and registers the decision
`timescale 1ns/100ps

module lc4_pair_issue (
    input  logic                   gwe,
    input  logic                   i_reset,
    input  logic                   i_fetch_valid,
    input  lc4_isa_pkg::reg_idx_t  i_rs_a,
    input  lc4_isa_pkg::reg_idx_t  i_rt_a,
    input  lc4_isa_pkg::reg_idx_t  i_rd_a,
    input  logic                   i_rs_re_a,
    input  logic                   i_rt_re_a,
    input  logic                   i_rd_we_a,
    input  logic                   i_nzp_we_a,
    input  logic                   i_is_load_a,
    input  logic                   i_is_store_a,
    input  logic                   i_is_branch_a,
    input  lc4_isa_pkg::reg_idx_t  i_rs_b,
    input  lc4_isa_pkg::reg_idx_t  i_rt_b,
    input  lc4_isa_pkg::reg_idx_t  i_rd_b,
    input  logic                   i_rs_re_b,
    input  logic                   i_rt_re_b,
    input  logic                   i_rd_we_b,
    input  logic                   i_nzp_we_b,
    input  logic                   i_is_load_b,
    input  logic                   i_is_store_b,
    input  logic                   i_is_branch_b,
    output logic                   o_issue_valid,
    output logic                   o_issue_a,
    output logic                   o_issue_b,
    output logic                   o_pipe_switch,
    output lc4_issue_pkg::stall_e  o_stall_a,
    output lc4_issue_pkg::stall_e  o_stall_b
);

    // loads issued on the previous strobe, one slot per lane
    logic                  ld_valid_a;
    logic                  ld_valid_b;
    logic                  ld_nzp;
    lc4_isa_pkg::reg_idx_t ld_rd_a;
    lc4_isa_pkg::reg_idx_t ld_rd_b;

    logic                  ltu_a;
    logic                  ltu_b;
    logic                  b_needs_a;
    logic                  mem_pair;
    logic                  issue_a;
    logic                  issue_b;
    logic                  pipe_switch;
    lc4_issue_pkg::stall_e stall_a;
    lc4_issue_pkg::stall_e stall_b;

    function automatic logic reads_reg(
        input lc4_isa_pkg::reg_idx_t rs,
        input logic                  rs_re,
        input lc4_isa_pkg::reg_idx_t rt,
        input logic                  rt_re,
        input lc4_isa_pkg::reg_idx_t r
    );
        return (rs_re && (rs == r)) || (rt_re && (rt == r));
    endfunction

    // a branch waits on any load since every load writes NZP
    assign ltu_a = (ld_valid_a && reads_reg(i_rs_a, i_rs_re_a, i_rt_a, i_rt_re_a, ld_rd_a))
                || (ld_valid_b && reads_reg(i_rs_a, i_rs_re_a, i_rt_a, i_rt_re_a, ld_rd_b))
                || (i_is_branch_a && ld_nzp);

    assign ltu_b = (ld_valid_a && reads_reg(i_rs_b, i_rs_re_b, i_rt_b, i_rt_re_b, ld_rd_a))
                || (ld_valid_b && reads_reg(i_rs_b, i_rs_re_b, i_rt_b, i_rt_re_b, ld_rd_b))
                || (i_is_branch_b && ld_nzp);

    assign b_needs_a = (i_rd_we_a && reads_reg(i_rs_b, i_rs_re_b, i_rt_b, i_rt_re_b, i_rd_a))
                    || (i_is_branch_b && i_nzp_we_a);

    // only one data memory port
    assign mem_pair = (i_is_load_a || i_is_store_a) && (i_is_load_b || i_is_store_b);

    always_comb begin
        issue_a     = 1'b1;
        issue_b     = 1'b1;
        pipe_switch = 1'b0;
        stall_a     = lc4_issue_pkg::STALL_NONE;
        stall_b     = lc4_issue_pkg::STALL_NONE;

        if (ltu_a) begin
            // B is younger and cannot pass A
            issue_a = 1'b0;
            issue_b = 1'b0;
            stall_a = lc4_issue_pkg::STALL_LOAD;
            stall_b = lc4_issue_pkg::STALL_PIPE;
        end else if (ltu_b) begin
            issue_b     = 1'b0;
            stall_b     = lc4_issue_pkg::STALL_LOAD;
            pipe_switch = 1'b1;
        end else if (b_needs_a || mem_pair) begin
            issue_b     = 1'b0;
            stall_b     = lc4_issue_pkg::STALL_PIPE;
            pipe_switch = 1'b1;
        end
    end

    always_ff @(posedge gwe) begin
        if (i_reset) begin
            o_issue_valid <= 1'b0;
            o_issue_a     <= 1'b0;
            o_issue_b     <= 1'b0;
            o_pipe_switch <= 1'b0;
            o_stall_a     <= lc4_issue_pkg::STALL_NONE;
            o_stall_b     <= lc4_issue_pkg::STALL_NONE;
            ld_valid_a    <= 1'b0;
            ld_valid_b    <= 1'b0;
            ld_nzp        <= 1'b0;
        end else if (i_fetch_valid) begin
            o_issue_valid <= 1'b1;
            o_issue_a     <= issue_a;
            o_issue_b     <= issue_b;
            o_pipe_switch <= pipe_switch;
            o_stall_a     <= stall_a;
            o_stall_b     <= stall_b;
            // a stalled lane leaves nothing behind in the record
            ld_valid_a    <= issue_a && i_is_load_a && i_rd_we_a;
            ld_valid_b    <= issue_b && i_is_load_b && i_rd_we_b;
            ld_nzp        <= (issue_a && i_is_load_a && i_nzp_we_a)
                          || (issue_b && i_is_load_b && i_nzp_we_b);
        end else begin
            o_issue_valid <= 1'b0;
            o_issue_a     <= 1'b0;
            o_issue_b     <= 1'b0;
            o_pipe_switch <= 1'b0;
            o_stall_a     <= lc4_issue_pkg::STALL_NONE;
            o_stall_b     <= lc4_issue_pkg::STALL_NONE;
            ld_valid_a    <= 1'b0;
            ld_valid_b    <= 1'b0;
            ld_nzp        <= 1'b0;
        end
    end

    // destination numbers only matter while the valid bits are set
    always_ff @(posedge gwe) begin
        ld_rd_a <= i_rd_a;
        ld_rd_b <= i_rd_b;
    end

endmodule

/* hdl/lc4_dual_issue.sv */
// LC4 dual-issue stage
// two lane decoders feeding the pair issue unit
`timescale 1ns/100ps
`include "lc4_consts.svh"

module lc4_dual_issue (
    input  logic                    gwe,
    input  logic                    i_reset,
    input  logic                    i_fetch_valid,
    input  logic [`LC4_INSN_W-1:0]  i_insn_a,
    input  logic [`LC4_INSN_W-1:0]  i_insn_b,
    output logic                    o_issue_valid,
    output logic                    o_issue_a,
    output logic                    o_issue_b,
    output lc4_issue_pkg::stall_e   o_stall_a,
    output lc4_issue_pkg::stall_e   o_stall_b,
    output logic                    o_pipe_switch
);

    // lane A, the older instruction
    lc4_isa_pkg::reg_idx_t rs_a, rt_a, rd_a;
    logic                  rs_re_a, rt_re_a, rd_we_a, nzp_we_a;
    logic                  is_load_a, is_store_a, is_branch_a;

    // lane B
    lc4_isa_pkg::reg_idx_t rs_b, rt_b, rd_b;
    logic                  rs_re_b, rt_re_b, rd_we_b, nzp_we_b;
    logic                  is_load_b, is_store_b, is_branch_b;

    lc4_insn_decoder u_decode_a (
        .i_insn(i_insn_a), .o_rs(rs_a), .o_rt(rt_a), .o_rd(rd_a),
        .o_rs_re(rs_re_a), .o_rt_re(rt_re_a), .o_rd_we(rd_we_a), .o_nzp_we(nzp_we_a),
        .o_is_load(is_load_a), .o_is_store(is_store_a), .o_is_branch(is_branch_a)
    );

    lc4_insn_decoder u_decode_b (
        .i_insn(i_insn_b), .o_rs(rs_b), .o_rt(rt_b), .o_rd(rd_b),
        .o_rs_re(rs_re_b), .o_rt_re(rt_re_b), .o_rd_we(rd_we_b), .o_nzp_we(nzp_we_b),
        .o_is_load(is_load_b), .o_is_store(is_store_b), .o_is_branch(is_branch_b)
    );

    lc4_pair_issue u_pair_issue (
        .gwe(gwe), .i_reset(i_reset), .i_fetch_valid(i_fetch_valid),
        .i_rs_a(rs_a), .i_rt_a(rt_a), .i_rd_a(rd_a),
        .i_rs_re_a(rs_re_a), .i_rt_re_a(rt_re_a), .i_rd_we_a(rd_we_a),
        .i_nzp_we_a(nzp_we_a), .i_is_load_a(is_load_a),
        .i_is_store_a(is_store_a), .i_is_branch_a(is_branch_a),
        .i_rs_b(rs_b), .i_rt_b(rt_b), .i_rd_b(rd_b),
        .i_rs_re_b(rs_re_b), .i_rt_re_b(rt_re_b), .i_rd_we_b(rd_we_b),
        .i_nzp_we_b(nzp_we_b), .i_is_load_b(is_load_b),
        .i_is_store_b(is_store_b), .i_is_branch_b(is_branch_b),
        .o_issue_valid(o_issue_valid), .o_issue_a(o_issue_a), .o_issue_b(o_issue_b),
        .o_pipe_switch(o_pipe_switch), .o_stall_a(o_stall_a), .o_stall_b(o_stall_b)
    );

endmodule

/* verif/lc4_tb_clock.sv */
// testbench clock source
// free-running clock, 10 ns period by default
`timescale 1ns/100ps

module lc4_tb_clock #(
    parameter real PERIOD_NS = 10.0
) (
    output logic o_clk
);

    initial begin
        o_clk = 1'b0;
    end

    // first rising edge lands at half a period
    always #(PERIOD_NS / 2.0) o_clk = ~o_clk;

endmodule

/* verif/lc4_dual_issue_tb.sv */
// LC4 dual-issue stage testbench
// table-driven pairs and a seeded random tail checked against an issue-rule model
`timescale 1ns/100ps
`include "lc4_consts.svh"

module lc4_dual_issue_tb;

    localparam int RAND_COUNT = 40;

    localparam logic [3:0] BR    = lc4_isa_pkg::OP_BR;
    localparam logic [3:0] ADD   = lc4_isa_pkg::OP_ARITH;
    localparam logic [3:0] LOG   = lc4_isa_pkg::OP_LOGIC;
    localparam logic [3:0] LDR   = lc4_isa_pkg::OP_LDR;
    localparam logic [3:0] STR   = lc4_isa_pkg::OP_STR;
    localparam logic [3:0] CON   = lc4_isa_pkg::OP_CONST;
    // an opcode outside the decoded classes
    localparam logic [3:0] OTHER = 4'hD;

    localparam lc4_issue_pkg::stall_e S_NONE = lc4_issue_pkg::STALL_NONE;
    localparam lc4_issue_pkg::stall_e S_PIPE = lc4_issue_pkg::STALL_PIPE;
    localparam lc4_issue_pkg::stall_e S_LOAD = lc4_issue_pkg::STALL_LOAD;

    logic                   gwe;
    logic                   reset;
    logic                   fetch_valid;
    logic [`LC4_INSN_W-1:0] insn_a;
    logic [`LC4_INSN_W-1:0] insn_b;
    logic                   issue_valid;
    logic                   issue_a;
    logic                   issue_b;
    lc4_issue_pkg::stall_e  stall_a;
    lc4_issue_pkg::stall_e  stall_b;
    logic                   pipe_switch;

    // stimulus and expected results for each cycle
    logic                   q_rst[$];
    logic                   q_strobe[$];
    logic [`LC4_INSN_W-1:0] q_a[$];
    logic [`LC4_INSN_W-1:0] q_b[$];
    logic [1:0]             q_issue[$];
    lc4_issue_pkg::stall_e  q_sa[$];
    lc4_issue_pkg::stall_e  q_sb[$];
    logic                   q_sw[$];

    // model copy of the loads issued on the previous strobe
    logic                   rec_valid_a;
    logic                   rec_valid_b;
    lc4_isa_pkg::reg_idx_t  rec_rd_a;
    lc4_isa_pkg::reg_idx_t  rec_rd_b;

    integer seed;
    int     table_rows;
    int     cycle_limit = 0;
    int     cycle_count = 0;

    lc4_tb_clock u_clock (
        .o_clk(gwe)
    );

    lc4_dual_issue u_lc4_dual_issue (
        .gwe(gwe),
        .i_reset(reset),
        .i_fetch_valid(fetch_valid),
        .i_insn_a(insn_a),
        .i_insn_b(insn_b),
        .o_issue_valid(issue_valid),
        .o_issue_a(issue_a),
        .o_issue_b(issue_b),
        .o_stall_a(stall_a),
        .o_stall_b(stall_b),
        .o_pipe_switch(pipe_switch)
    );

    function automatic logic [`LC4_INSN_W-1:0] encode(
        input logic [3:0]            op,
        input lc4_isa_pkg::reg_idx_t rd,
        input lc4_isa_pkg::reg_idx_t rs,
        input logic                  imm_flag,
        input logic [4:0]            low
    );
        logic [`LC4_INSN_W-1:0] w;
        w = '0;
        w[`LC4_OPCODE_MSB:`LC4_OPCODE_LSB] = op;
        w[`LC4_RD_MSB:`LC4_RD_LSB] = rd;
        w[`LC4_RS_MSB:`LC4_RS_LSB] = rs;
        w[`LC4_IMM_FLAG_BIT] = imm_flag;
        w[`LC4_IMM_FLAG_BIT-1:0] = low;
        return w;
    endfunction

    function automatic logic reads_reg(
        input logic [`LC4_INSN_W-1:0] w,
        input lc4_isa_pkg::reg_idx_t  r
    );
        logic rs_hit;
        logic rt_hit;
        logic rd_hit;
        rs_hit = (w[`LC4_RS_MSB:`LC4_RS_LSB] == r);
        rt_hit = (w[`LC4_RT_MSB:`LC4_RT_LSB] == r);
        rd_hit = (w[`LC4_RD_MSB:`LC4_RD_LSB] == r);
        case (w[`LC4_OPCODE_MSB:`LC4_OPCODE_LSB])
            ADD, LOG: return rs_hit || (!w[`LC4_IMM_FLAG_BIT] && rt_hit);
            LDR:      return rs_hit;
            // store data comes from the rd field
            STR:      return rs_hit || rd_hit;
            default:  return 1'b0;
        endcase
    endfunction

    // every writer in this opcode subset sets both rd and NZP
    function automatic logic writes_result(input logic [`LC4_INSN_W-1:0] w);
        logic [3:0] op;
        op = w[`LC4_OPCODE_MSB:`LC4_OPCODE_LSB];
        return (op == ADD) || (op == LOG) || (op == LDR) || (op == CON);
    endfunction

    function automatic logic is_memory_op(input logic [`LC4_INSN_W-1:0] w);
        return (w[`LC4_OPCODE_MSB:`LC4_OPCODE_LSB] == LDR)
            || (w[`LC4_OPCODE_MSB:`LC4_OPCODE_LSB] == STR);
    endfunction

    function automatic logic load_to_use(input logic [`LC4_INSN_W-1:0] w);
        logic is_br;
        is_br = (w[`LC4_OPCODE_MSB:`LC4_OPCODE_LSB] == BR);
        return (rec_valid_a && reads_reg(w, rec_rd_a))
            || (rec_valid_b && reads_reg(w, rec_rd_b))
            || (is_br && (rec_valid_a || rec_valid_b));
    endfunction

    // issue rules in priority order
    task automatic predict_pair(
        input  logic                   rst,
        input  logic                   strobe,
        input  logic [`LC4_INSN_W-1:0] a,
        input  logic [`LC4_INSN_W-1:0] b,
        output logic [1:0]             issue,
        output lc4_issue_pkg::stall_e  sa,
        output lc4_issue_pkg::stall_e  sb,
        output logic                   sw
    );
        logic needs_a;
        needs_a = (writes_result(a) && reads_reg(b, a[`LC4_RD_MSB:`LC4_RD_LSB]))
               || ((b[`LC4_OPCODE_MSB:`LC4_OPCODE_LSB] == BR) && writes_result(a));
        issue = 2'b00;
        sa = S_NONE;
        sb = S_NONE;
        sw = 1'b0;
        if (strobe && !rst) begin
            if (load_to_use(a)) begin
                sa = S_LOAD;
                sb = S_PIPE;
            end else if (load_to_use(b)) begin
                issue = 2'b10;
                sb = S_LOAD;
                sw = 1'b1;
            end else if (needs_a || (is_memory_op(a) && is_memory_op(b))) begin
                issue = 2'b10;
                sb = S_PIPE;
                sw = 1'b1;
            end else begin
                issue = 2'b11;
            end
        end
    endtask

    task automatic stop_on_failure();
        $display("Regression failed");
        $fatal(1, "stopping at the first failure");
    endtask

    task automatic add_row(
        input logic                   rst,
        input logic                   strobe,
        input logic [`LC4_INSN_W-1:0] a,
        input logic [`LC4_INSN_W-1:0] b,
        input logic [1:0]             issue,
        input lc4_issue_pkg::stall_e  sa,
        input lc4_issue_pkg::stall_e  sb,
        input logic                   sw
    );
        logic [1:0]            m_issue;
        lc4_issue_pkg::stall_e m_sa;
        lc4_issue_pkg::stall_e m_sb;
        logic                  m_sw;
        predict_pair(rst, strobe, a, b, m_issue, m_sa, m_sb, m_sw);
        if (m_issue !== issue || m_sa !== sa || m_sb !== sb || m_sw !== sw) begin
            $display("table row %0d does not follow the issue rules", q_a.size());
            stop_on_failure();
        end
        q_rst.push_back(rst);
        q_strobe.push_back(strobe);
        q_a.push_back(a);
        q_b.push_back(b);
        q_issue.push_back(issue);
        q_sa.push_back(sa);
        q_sb.push_back(sb);
        q_sw.push_back(sw);
        // only loads that actually issued on a strobe stay in the record
        rec_valid_a = strobe && !rst && m_issue[1] && (a[`LC4_OPCODE_MSB:`LC4_OPCODE_LSB] == LDR);
        rec_valid_b = strobe && !rst && m_issue[0] && (b[`LC4_OPCODE_MSB:`LC4_OPCODE_LSB] == LDR);
        rec_rd_a = a[`LC4_RD_MSB:`LC4_RD_LSB];
        rec_rd_b = b[`LC4_RD_MSB:`LC4_RD_LSB];
    endtask

    task automatic build_table();
        // independent pairs back to back and then a gap
        add_row(0, 1, encode(ADD, 1, 2, 0, 3), encode(LOG, 4, 5, 0, 6), 2'b11, S_NONE, S_NONE, 0);
        add_row(0, 1, encode(CON, 2, 0, 0, 0), encode(ADD, 5, 6, 0, 7), 2'b11, S_NONE, S_NONE, 0);
        add_row(0, 1, encode(LOG, 3, 0, 1, 4), encode(CON, 6, 0, 0, 0), 2'b11, S_NONE, S_NONE, 0);
        add_row(0, 0, '0, '0, 2'b00, S_NONE, S_NONE, 0);
        // B depends on A through a register or NZP
        add_row(0, 1, encode(ADD, 1, 2, 0, 3), encode(ADD, 4, 1, 0, 5), 2'b10, S_NONE, S_PIPE, 1);
        add_row(0, 1, encode(CON, 2, 0, 0, 0), encode(BR, 0, 0, 0, 0), 2'b10, S_NONE, S_PIPE, 1);
        // immediate bits equal to A's rd are not a read
        add_row(0, 1, encode(ADD, 3, 0, 0, 1), encode(ADD, 4, 5, 1, 3), 2'b11, S_NONE, S_NONE, 0);
        // load and store share the memory port
        add_row(0, 1, encode(LDR, 1, 2, 0, 0), encode(STR, 3, 4, 0, 0), 2'b10, S_NONE, S_PIPE, 1);
        add_row(0, 0, '0, '0, 2'b00, S_NONE, S_NONE, 0);
        // load-to-use in lane A and then the same pair again
        add_row(0, 1, encode(LDR, 2, 0, 0, 0), encode(CON, 5, 0, 0, 0), 2'b11, S_NONE, S_NONE, 0);
        add_row(0, 1, encode(ADD, 3, 2, 0, 1), encode(CON, 6, 0, 0, 0), 2'b00, S_LOAD, S_PIPE, 0);
        add_row(0, 1, encode(ADD, 3, 2, 0, 1), encode(CON, 6, 0, 0, 0), 2'b11, S_NONE, S_NONE, 0);
        // load-to-use in lane B only
        add_row(0, 1, encode(CON, 0, 0, 0, 0), encode(LDR, 4, 1, 0, 0), 2'b11, S_NONE, S_NONE, 0);
        add_row(0, 1, encode(ADD, 5, 0, 0, 1), encode(ADD, 6, 4, 0, 2), 2'b10, S_NONE, S_LOAD, 1);
        // branches right after a load
        add_row(0, 1, encode(LDR, 3, 1, 0, 0), encode(CON, 7, 0, 0, 0), 2'b11, S_NONE, S_NONE, 0);
        add_row(0, 1, encode(BR, 0, 0, 0, 0), encode(CON, 0, 0, 0, 0), 2'b00, S_LOAD, S_PIPE, 0);
        add_row(0, 1, encode(LDR, 2, 5, 0, 0), encode(CON, 6, 0, 0, 0), 2'b11, S_NONE, S_NONE, 0);
        add_row(0, 1, encode(CON, 1, 0, 0, 0), encode(BR, 0, 0, 0, 0), 2'b10, S_NONE, S_LOAD, 1);
        // a gap between load and user hides the hazard
        add_row(0, 1, encode(LDR, 4, 3, 0, 0), encode(CON, 0, 0, 0, 0), 2'b11, S_NONE, S_NONE, 0);
        add_row(0, 0, '0, '0, 2'b00, S_NONE, S_NONE, 0);
        add_row(0, 1, encode(ADD, 5, 4, 0, 4), encode(CON, 1, 0, 0, 0), 2'b11, S_NONE, S_NONE, 0);
        // reset mid-run drops the pending load
        add_row(0, 1, encode(LDR, 1, 2, 0, 0), encode(CON, 5, 0, 0, 0), 2'b11, S_NONE, S_NONE, 0);
        add_row(1, 1, encode(ADD, 2, 1, 0, 3), encode(CON, 6, 0, 0, 0), 2'b00, S_NONE, S_NONE, 0);
        add_row(0, 1, encode(ADD, 2, 1, 0, 3), encode(CON, 6, 0, 0, 0), 2'b11, S_NONE, S_NONE, 0);
    endtask

    function automatic logic [`LC4_INSN_W-1:0] random_insn();
        logic [`LC4_INSN_W-1:0] w;
        w = $random(seed);
        case ($unsigned($random(seed)) % 8)
            0:       w[`LC4_OPCODE_MSB:`LC4_OPCODE_LSB] = BR;
            1:       w[`LC4_OPCODE_MSB:`LC4_OPCODE_LSB] = ADD;
            2:       w[`LC4_OPCODE_MSB:`LC4_OPCODE_LSB] = LOG;
            3, 4:    w[`LC4_OPCODE_MSB:`LC4_OPCODE_LSB] = LDR;
            5:       w[`LC4_OPCODE_MSB:`LC4_OPCODE_LSB] = STR;
            6:       w[`LC4_OPCODE_MSB:`LC4_OPCODE_LSB] = CON;
            default: w[`LC4_OPCODE_MSB:`LC4_OPCODE_LSB] = OTHER;
        endcase
        // keep to r0..r3 so register collisions are common
        w[`LC4_RD_MSB] = 1'b0;
        w[`LC4_RS_MSB] = 1'b0;
        w[`LC4_RT_MSB] = 1'b0;
        return w;
    endfunction

    task automatic add_random_tail();
        logic [`LC4_INSN_W-1:0] a;
        logic [`LC4_INSN_W-1:0] b;
        logic                   strobe;
        logic [1:0]             issue;
        lc4_issue_pkg::stall_e  sa;
        lc4_issue_pkg::stall_e  sb;
        logic                   sw;
        for (int n = 0; n < RAND_COUNT; n++) begin
            a = random_insn();
            b = random_insn();
            strobe = (($random(seed) & 3) != 0);
            predict_pair(1'b0, strobe, a, b, issue, sa, sb, sw);
            add_row(1'b0, strobe, a, b, issue, sa, sb, sw);
        end
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[ERROR] %0t: %s is %b, expected %b", $time, what, got, exp);
            stop_on_failure();
        end
    endtask

    task automatic check_stall(
        input string                 what,
        input lc4_issue_pkg::stall_e got,
        input lc4_issue_pkg::stall_e exp
    );
        if (got !== exp) begin
            $display("[ERROR] %0t: %s is %0d, expected %0d", $time, what, got, exp);
            stop_on_failure();
        end
    endtask

    task automatic check_outputs(
        input string                 tag,
        input logic                  valid,
        input logic [1:0]            issue,
        input lc4_issue_pkg::stall_e sa,
        input lc4_issue_pkg::stall_e sb,
        input logic                  sw
    );
        check_flag({tag, " o_issue_valid"}, issue_valid, valid);
        check_flag({tag, " o_issue_a"}, issue_a, issue[1]);
        check_flag({tag, " o_issue_b"}, issue_b, issue[0]);
        check_stall({tag, " o_stall_a"}, stall_a, sa);
        check_stall({tag, " o_stall_b"}, stall_b, sb);
        check_flag({tag, " o_pipe_switch"}, pipe_switch, sw);
    endtask

    task automatic drive_row(input int k);
        reset       = q_rst[k];
        fetch_valid = q_strobe[k];
        insn_a      = q_a[k];
        insn_b      = q_b[k];
    endtask

    always @(posedge gwe) begin
        cycle_count = cycle_count + 1;
        if (cycle_limit > 0 && cycle_count > cycle_limit) begin
            $display("timeout: results never completed");
            stop_on_failure();
        end
    end

    initial begin
        reset        = 1'b1;
        fetch_valid  = 1'b0;
        insn_a       = '0;
        insn_b       = '0;
        seed         = 39;
        rec_valid_a  = 1'b0;
        rec_valid_b  = 1'b0;
        rec_rd_a     = '0;
        rec_rd_b     = '0;

        build_table();
        table_rows = q_a.size();
        add_random_tail();
        cycle_limit = table_rows + RAND_COUNT + 20;

        repeat (3) @(posedge gwe);
        #1;
        check_outputs("after reset", 1'b0, 2'b00, S_NONE, S_NONE, 1'b0);

        // result of each row appears one edge after it is driven
        for (int k = 0; k < q_a.size(); k++) begin
            drive_row(k);
            @(posedge gwe);
            #1;
            check_outputs($sformatf("row %0d", k), q_strobe[k] && !q_rst[k],
                          q_issue[k], q_sa[k], q_sb[k], q_sw[k]);
        end

        $display("Regression passed");
        $finish;
    end

endmodule

/* build.f */
+incdir+hdl
hdl/lc4_isa_pkg.sv
hdl/lc4_issue_pkg.sv
hdl/lc4_insn_decoder.sv
hdl/lc4_pair_issue.sv
hdl/lc4_dual_issue.sv
verif/lc4_tb_clock.sv
verif/lc4_dual_issue_tb.sv

/* Bender.yml */
package:
  name: lc4_dual_issue

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/lc4_isa_pkg.sv
      - hdl/lc4_issue_pkg.sv
      - hdl/lc4_insn_decoder.sv
      - hdl/lc4_pair_issue.sv
      - hdl/lc4_dual_issue.sv

  - target: simulation
    include_dirs:
      - hdl
    files:
      - verif/lc4_tb_clock.sv
      - verif/lc4_dual_issue_tb.sv
